/* design/hyper_cfg_pkg.sv */
// HyperBus controller configuration definitions
// Register map, latency type and register port structs

package hyper_cfg_pkg;

    typedef logic [3:0]  latency_t;
    typedef logic [31:0] count_t;
    typedef logic [7:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    typedef struct packed {
        logic      valid;
        logic      write;
        reg_addr_t addr;
        reg_data_t wdata;
    } reg_req_t;

    typedef struct packed {
        logic      ready;
        logic      error;
        reg_data_t rdata;
    } reg_rsp_t;

    // Register map
    localparam reg_addr_t RegLatency = 8'h00;
    localparam reg_addr_t RegCount   = 8'h04;

    localparam latency_t LatencyReset = 4'd6;
    localparam latency_t LatencyMin   = 4'd2;

endpackage

/* design/hyper_bus_pkg.sv */
// HyperBus memory side definitions
// Data word, address and command-address types, system port structs
// and the PHY state encoding

package hyper_bus_pkg;

    typedef logic [15:0] word_t;
    typedef logic [23:0] addr_t;
    typedef logic [7:0]  dq_t;

    // Command-address, sent most significant byte first
    // 47 read flag, 46 address space, 45 burst type, 23:0 word address
    typedef logic [47:0] ca_t;

    localparam int CaBytes = 6;

    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  write;
        word_t rdata;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        PhyIdle,
        PhyCa,
        PhyLatency,
        PhyWrite,
        PhyRead,
        PhyRsp
    } phy_state_t;

endpackage

/* design/hyper_regs.sv */
// HyperBus controller register block
// Holds the initial access latency and counts completed transactions

`timescale 1ns/1ns

module hyper_regs import hyper_cfg_pkg::*; (
    input  logic     sys_clk,
    input  logic     reset_i,
    input  reg_req_t reg_req_i,
    output reg_rsp_t reg_rsp_o,
    input  logic     done_i,
    output latency_t latency_o
);

    latency_t latency_q;
    count_t   count_q;
    latency_t latency_wr;
    logic     hit_latency;
    logic     hit_count;

    assign hit_latency = (reg_req_i.addr == RegLatency);
    assign hit_count   = (reg_req_i.addr == RegCount);

    // Values below the minimum are clamped on write
    assign latency_wr = (latency_t'(reg_req_i.wdata) < LatencyMin) ?
                        LatencyMin : latency_t'(reg_req_i.wdata);

    always_comb begin
        reg_rsp_o.ready = reg_req_i.valid;
        reg_rsp_o.error = reg_req_i.valid &&
                          (!(hit_latency || hit_count) || (reg_req_i.write && hit_count));
        if (hit_latency) begin
            reg_rsp_o.rdata = reg_data_t'(latency_q);
        end else if (hit_count) begin
            reg_rsp_o.rdata = count_q;
        end else begin
            reg_rsp_o.rdata = '0;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            latency_q <= LatencyReset;
            count_q   <= '0;
        end else begin
            if (reg_req_i.valid && reg_req_i.write && hit_latency) begin
                latency_q <= latency_wr;
            end
            // One pulse per accepted response
            if (done_i) begin
                count_q <= count_q + 32'd1;
            end
        end
    end

    assign latency_o = latency_q;

endmodule

/* design/hyper_req_queue.sv */
// Two-entry request FIFO between the system port and the PHY
// Lets a second request wait while the PHY runs a transaction

`timescale 1ns/1ns

module hyper_req_queue import hyper_bus_pkg::*; (
    input  logic     sys_clk,
    input  logic     reset_i,
    input  mem_req_t req_i,
    input  logic     req_valid_i,
    output logic     req_ready_o,
    output mem_req_t req_o,
    output logic     req_valid_o,
    input  logic     req_ready_i
);

    mem_req_t   mem_q [2];
    logic       wr_ptr_q;
    logic       rd_ptr_q;
    logic [1:0] cnt_q;
    logic       push;
    logic       pop;

    assign push = req_valid_i && req_ready_o;
    assign pop  = req_valid_o && req_ready_i;

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            cnt_q    <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            case ({push, pop})
                2'b10:   cnt_q <= cnt_q + 2'd1;
                2'b01:   cnt_q <= cnt_q - 2'd1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    // Storage entries
    always_ff @(posedge sys_clk) begin
        if (push) begin
            mem_q[wr_ptr_q] <= req_i;
        end
    end

    assign req_o       = mem_q[rd_ptr_q];
    assign req_valid_o = (cnt_q != 2'd0);
    assign req_ready_o = (cnt_q != 2'd2);

endmodule

/* design/hyper_phy.sv */
// HyperBus PHY for single-word transactions
// Sends the command-address, waits the access latency, then writes
// or captures one 16-bit word and returns a response

`timescale 1ns/1ns

module hyper_phy
    import hyper_bus_pkg::*;
    import hyper_cfg_pkg::*;
(
    input  logic     sys_clk,
    input  logic     reset_i,
    input  mem_req_t req_i,
    input  logic     req_valid_i,
    output logic     req_ready_o,
    input  latency_t latency_i,
    output mem_rsp_t rsp_o,
    output logic     rsp_valid_o,
    input  logic     rsp_ready_i,
    output logic     done_o,
    output logic     hyper_cs_no,
    output logic     hyper_ck_o,
    output logic     hyper_rwds_o,
    input  logic     hyper_rwds_i,
    output logic     hyper_rwds_oe_o,
    output dq_t      hyper_dq_o,
    input  dq_t      hyper_dq_i,
    output logic     hyper_dq_oe_o
);

    phy_state_t state_q;
    logic [2:0] byte_cnt_q;
    latency_t   lat_cnt_q;
    latency_t   lat_q;
    ca_t        ca_q;
    ca_t        ca_new;
    logic       write_q;
    word_t      wdata_q;
    word_t      rdata_q;
    logic       accept;
    logic       rd_byte;

    assign accept  = req_valid_i && req_ready_o;
    assign rd_byte = (state_q == PhyRead) && hyper_rwds_i;

    // Read flag, memory space, linear burst, word address
    always_comb begin
        ca_new        = '0;
        ca_new[47]    = ~req_i.write;
        ca_new[46]    = 1'b0;
        ca_new[45]    = 1'b1;
        ca_new[23:0]  = req_i.addr;
    end

    always_ff @(posedge sys_clk) begin
        if (reset_i) begin
            state_q    <= PhyIdle;
            byte_cnt_q <= '0;
            lat_cnt_q  <= '0;
        end else begin
            case (state_q)
                PhyIdle: begin
                    if (req_valid_i) begin
                        state_q    <= PhyCa;
                        byte_cnt_q <= '0;
                    end
                end
                PhyCa: begin
                    if (byte_cnt_q == 3'(CaBytes - 1)) begin
                        state_q   <= PhyLatency;
                        lat_cnt_q <= '0;
                    end else begin
                        byte_cnt_q <= byte_cnt_q + 3'd1;
                    end
                end
                PhyLatency: begin
                    if (lat_cnt_q == lat_q - 4'd1) begin
                        state_q    <= write_q ? PhyWrite : PhyRead;
                        byte_cnt_q <= '0;
                    end else begin
                        lat_cnt_q <= lat_cnt_q + 4'd1;
                    end
                end
                PhyWrite: begin
                    if (byte_cnt_q == 3'd1) begin
                        state_q <= PhyRsp;
                    end else begin
                        byte_cnt_q <= byte_cnt_q + 3'd1;
                    end
                end
                PhyRead: begin
                    // Memory marks each valid byte with RWDS
                    if (hyper_rwds_i) begin
                        if (byte_cnt_q == 3'd1) begin
                            state_q <= PhyRsp;
                        end else begin
                            byte_cnt_q <= byte_cnt_q + 3'd1;
                        end
                    end
                end
                PhyRsp: begin
                    if (rsp_ready_i) begin
                        state_q <= PhyIdle;
                    end
                end
                default: state_q <= PhyIdle;
            endcase
        end
    end

    // Transaction payload
    always_ff @(posedge sys_clk) begin
        if (accept) begin
            write_q <= req_i.write;
            wdata_q <= req_i.wdata;
            lat_q   <= latency_i;
            ca_q    <= ca_new;
            rdata_q <= '0;
        end else if (state_q == PhyCa) begin
            ca_q <= ca_q << 8;
        end else if (rd_byte) begin
            if (byte_cnt_q[0]) begin
                rdata_q[7:0] <= hyper_dq_i;
            end else begin
                rdata_q[15:8] <= hyper_dq_i;
            end
        end
    end

    assign req_ready_o = (state_q == PhyIdle);
    assign rsp_valid_o = (state_q == PhyRsp);
    assign done_o      = rsp_valid_o && rsp_ready_i;
    assign rsp_o       = '{write: write_q, rdata: rdata_q};

    // Bus pins decoded from the state, SDR with one byte per cycle
    assign hyper_cs_no     = (state_q == PhyIdle) || (state_q == PhyRsp);
    assign hyper_ck_o      = ~hyper_cs_no;
    assign hyper_dq_oe_o   = (state_q == PhyCa) || (state_q == PhyWrite);
    assign hyper_rwds_oe_o = (state_q == PhyWrite);
    assign hyper_rwds_o    = 1'b0;

    always_comb begin
        case (state_q)
            PhyCa:    hyper_dq_o = ca_q[47:40];
            PhyWrite: hyper_dq_o = byte_cnt_q[0] ? wdata_q[7:0] : wdata_q[15:8];
            default:  hyper_dq_o = '0;
        endcase
    end

endmodule

/* design/hyper_ctrl.sv */
// HyperBus memory controller top level
// Request queue, PHY and register block

`timescale 1ns/1ns

module hyper_ctrl
    import hyper_bus_pkg::*;
    import hyper_cfg_pkg::*;
(
    input  logic     sys_clk,
    input  logic     reset_i,
    input  mem_req_t mem_req_i,
    input  logic     req_valid_i,
    output logic     req_ready_o,
    output mem_rsp_t rsp_o,
    output logic     rsp_valid_o,
    input  logic     rsp_ready_i,
    input  reg_req_t reg_req_i,
    output reg_rsp_t reg_rsp_o,
    output logic     hyper_cs_no,
    output logic     hyper_ck_o,
    output logic     hyper_rwds_o,
    input  logic     hyper_rwds_i,
    output logic     hyper_rwds_oe_o,
    output dq_t      hyper_dq_o,
    input  dq_t      hyper_dq_i,
    output logic     hyper_dq_oe_o
);

    mem_req_t q_req;
    logic     q_valid;
    logic     q_ready;
    logic     done;
    latency_t latency;

    hyper_req_queue hyper_req_queue_i (
        .sys_clk     (sys_clk),
        .reset_i     (reset_i),
        .req_i       (mem_req_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_o       (q_req),
        .req_valid_o (q_valid),
        .req_ready_i (q_ready)
    );

    hyper_phy hyper_phy_i (
        .sys_clk         (sys_clk),
        .reset_i         (reset_i),
        .req_i           (q_req),
        .req_valid_i     (q_valid),
        .req_ready_o     (q_ready),
        .latency_i       (latency),
        .rsp_o           (rsp_o),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_ready_i     (rsp_ready_i),
        .done_o          (done),
        .hyper_cs_no     (hyper_cs_no),
        .hyper_ck_o      (hyper_ck_o),
        .hyper_rwds_o    (hyper_rwds_o),
        .hyper_rwds_i    (hyper_rwds_i),
        .hyper_rwds_oe_o (hyper_rwds_oe_o),
        .hyper_dq_o      (hyper_dq_o),
        .hyper_dq_i      (hyper_dq_i),
        .hyper_dq_oe_o   (hyper_dq_oe_o)
    );

    hyper_regs hyper_regs_i (
        .sys_clk   (sys_clk),
        .reset_i   (reset_i),
        .reg_req_i (reg_req_i),
        .reg_rsp_o (reg_rsp_o),
        .done_i    (done),
        .latency_o (latency)
    );

endmodule

/* tests/hyper_mem_model.sv */
// Behavioral HyperBus memory for the controller testbench
// Decodes the command-address, stores and returns words, checks bus timing

`timescale 1ns/1ns

module hyper_mem_model import hyper_bus_pkg::*; (
    input  logic        sys_clk,
    input  logic        cs_ni,
    input  logic        ck_i,
    input  dq_t         dq_i,
    input  logic        dq_oe_i,
    input  logic        rwds_i,
    input  logic        rwds_oe_i,
    output dq_t         dq_bus_o,
    output logic        rwds_bus_o,
    input  logic        exp_write_i,
    input  addr_t       exp_addr_i,
    input  logic [3:0]  exp_lat_i,
    input  logic [1:0]  delay_i,
    output int          errors_o
);

    word_t mem [256];
    dq_t   mem_dq;
    logic  mem_oe;
    ca_t   ca;
    ca_t   exp_ca;
    int    k = 0;
    int    lat_end;
    int    rd_at;
    int    err_cnt = 0;
    logic  wr_win;
    logic  oe_exp;

    // Shim joins both drivers of the shared DQ and RWDS lines
    assign dq_bus_o   = dq_oe_i ? dq_i : (mem_oe ? mem_dq : 8'h00);
    assign rwds_bus_o = rwds_oe_i ? rwds_i : mem_oe;
    assign errors_o   = err_cnt;

    initial begin
        mem_oe = 1'b0;
        mem_dq = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[7:0], ~i[7:0]};
        end
    end

    always @(posedge sys_clk) begin
        if (cs_ni !== 1'b0) begin
            k = 0;
            mem_oe <= 1'b0;
        end else begin
            assert (ck_i === 1'b1) else begin
                $display("Memory clock not high at cycle %0d after chip select", k);
                err_cnt++;
            end
            if (k < CaBytes) begin
                ca = {ca[39:0], dq_bus_o};
            end
            if (k == CaBytes - 1) begin
                exp_ca = {~exp_write_i, 2'b01, 21'd0, exp_addr_i};
                assert (ca == exp_ca) else begin
                    $display("** Error ca: expected %h, actual %h", exp_ca, ca);
                    err_cnt++;
                end
            end
            lat_end = CaBytes + int'(exp_lat_i);
            rd_at   = lat_end + int'(delay_i);
            wr_win  = !ca[47] && k >= lat_end && k <= lat_end + 1;
            // Controller drives only the CA bytes and the two write bytes
            oe_exp = (k < CaBytes) || wr_win;
            assert (dq_oe_i == oe_exp) else begin
                $display("DQ driven at the wrong cycle %0d after chip select, latency %0d",
                         k, exp_lat_i);
                err_cnt++;
            end
            // RWDS held low by the controller during the write bytes only
            assert ((rwds_oe_i == wr_win) && !(rwds_oe_i && rwds_i)) else begin
                $display("RWDS driven wrongly at cycle %0d after chip select", k);
                err_cnt++;
            end
            if (wr_win) begin
                if (k == lat_end) begin
                    mem[ca[7:0]][15:8] = dq_bus_o;
                end else begin
                    mem[ca[7:0]][7:0] = dq_bus_o;
                end
            end
            if (k >= CaBytes - 1 && ca[47]) begin
                mem_oe <= (k + 1 == rd_at) || (k + 1 == rd_at + 1);
                mem_dq <= (k + 1 == rd_at) ? mem[ca[7:0]][15:8] : mem[ca[7:0]][7:0];
            end
            k = k + 1;
        end
    end

endmodule

/* tests/hyper_ctrl_tb.sv */
// Testbench for the HyperBus controller
// Random write/read traffic, register access, back-pressure and counting

`timescale 1ns/1ns

module hyper_ctrl_tb import hyper_bus_pkg::*; import hyper_cfg_pkg::*; ();

    // About 30 transactions of under 40 cycles each, with margin
    localparam int MaxCycles = 4000;

    logic       sys_clk = 1'b0;
    logic       reset_i;
    mem_req_t   mem_req;
    logic       req_valid;
    logic       req_ready;
    logic       rsp_valid;
    logic       rsp_ready;
    mem_rsp_t   rsp;
    reg_req_t   reg_req;
    reg_rsp_t   reg_rsp;
    logic       cs_n;
    logic       ck;
    logic       rwds_o;
    logic       rwds_oe;
    logic       dq_oe;
    logic       rwds_bus;
    dq_t        dq_o;
    dq_t        dq_bus;
    logic       exp_write;
    addr_t      exp_addr;
    latency_t   exp_lat;
    logic [1:0] rd_delay;
    int         model_errors;
    word_t      ref_mem [256];
    logic [31:0] lfsr = 32'd84327;
    int         errors = 0;
    int         tests = 0;
    int         failed = 0;
    int         accepted = 0;
    int         cycles = 0;
    int         start_err;
    addr_t      addrs [6];
    addr_t      a;
    word_t      d [3];
    mem_rsp_t   held;
    mem_rsp_t   r;
    reg_rsp_t   rr;
    int         stall;

    always #50 sys_clk = ~sys_clk;

    hyper_ctrl hyper_ctrl_i (
        .sys_clk(sys_clk), .reset_i(reset_i),
        .mem_req_i(mem_req), .req_valid_i(req_valid), .req_ready_o(req_ready),
        .rsp_o(rsp), .rsp_valid_o(rsp_valid), .rsp_ready_i(rsp_ready),
        .reg_req_i(reg_req), .reg_rsp_o(reg_rsp),
        .hyper_cs_no(cs_n), .hyper_ck_o(ck), .hyper_rwds_o(rwds_o),
        .hyper_rwds_i(rwds_bus), .hyper_rwds_oe_o(rwds_oe), .hyper_dq_o(dq_o),
        .hyper_dq_i(dq_bus), .hyper_dq_oe_o(dq_oe)
    );

    hyper_mem_model mem_model_i (
        .sys_clk(sys_clk), .cs_ni(cs_n), .ck_i(ck), .dq_i(dq_o), .dq_oe_i(dq_oe),
        .rwds_i(rwds_o), .rwds_oe_i(rwds_oe), .dq_bus_o(dq_bus), .rwds_bus_o(rwds_bus),
        .exp_write_i(exp_write), .exp_addr_i(exp_addr), .exp_lat_i(exp_lat),
        .delay_i(rd_delay), .errors_o(model_errors)
    );

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic send_req(input logic write, input addr_t addr, input word_t data);
        @(posedge sys_clk);
        mem_req   <= '{write: write, addr: addr, wdata: data};
        req_valid <= 1'b1;
        exp_write <= write;
        exp_addr  <= addr;
        @(negedge sys_clk);
        while (!req_ready) @(negedge sys_clk);
        @(posedge sys_clk);
        req_valid <= 1'b0;
    endtask

    task automatic get_rsp(output mem_rsp_t got);
        @(negedge sys_clk);
        while (!(rsp_valid && rsp_ready)) @(negedge sys_clk);
        got = rsp;
        accepted++;
        @(posedge sys_clk);
    endtask

    task automatic mem_write(input addr_t addr, input word_t data);
        mem_rsp_t got;
        send_req(1'b1, addr, data);
        get_rsp(got);
        check("write response flag", 32'd1, 32'(got.write));
        ref_mem[addr[7:0]] = data;
    endtask

    task automatic mem_read(input string name, input addr_t addr);
        mem_rsp_t got;
        rd_delay <= 2'(take_bits(2));
        send_req(1'b0, addr, '0);
        get_rsp(got);
        check("read response flag", 32'd0, 32'(got.write));
        check(name, 32'(ref_mem[addr[7:0]]), 32'(got.rdata));
    endtask

    task automatic reg_access(input logic write, input reg_addr_t addr, input reg_data_t wdata,
                              output reg_rsp_t got);
        @(posedge sys_clk);
        reg_req <= '{valid: 1'b1, write: write, addr: addr, wdata: wdata};
        @(negedge sys_clk);
        got = reg_rsp;
        check("register ready", 32'd1, 32'(got.ready));
        @(posedge sys_clk);
        reg_req <= '0;
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors + model_errors == start_err) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: FAILED", name);
            failed++;
        end
        start_err = errors + model_errors;
    endtask

    always @(posedge sys_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MaxCycles) begin
            $display("Timeout after %0d cycles, a handshake never completed", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        reset_i   = 1'b1;
        mem_req   = '0;
        req_valid = 1'b0;
        rsp_ready = 1'b1;
        reg_req   = '0;
        exp_write = 1'b0;
        exp_addr  = '0;
        exp_lat   = LatencyReset;
        rd_delay  = '0;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = {i[7:0], ~i[7:0]};
        end
        repeat (2) @(posedge sys_clk);
        reset_i <= 1'b0;
        start_err = 0;

        // Idle bus and register values out of reset
        @(negedge sys_clk);
        check("reset req_ready", 32'd1, 32'(req_ready));
        check("reset rsp_valid", 32'd0, 32'(rsp_valid));
        check("reset cs_n", 32'd1, 32'(cs_n));
        check("reset dq_oe", 32'd0, 32'(dq_oe));
        check("reset rwds_oe", 32'd0, 32'(rwds_oe));
        reg_access(1'b0, RegLatency, '0, rr);
        check("reset latency", 32'(LatencyReset), rr.rdata);
        reg_access(1'b0, RegCount, '0, rr);
        check("reset count", 32'd0, rr.rdata);
        end_test("reset");

        for (int i = 0; i < 6; i++) begin
            addrs[i] = addr_t'(take_bits(24));
            mem_write(addrs[i], word_t'(take_bits(16)));
            mem_read("write_read", addrs[i]);
        end
        for (int i = 0; i < 6; i++) begin
            mem_read("write_read", addrs[i]);
        end
        end_test("write_read");

        reg_access(1'b1, RegLatency, 32'd1, rr);
        reg_access(1'b0, RegLatency, '0, rr);
        check("latency clamp", 32'(LatencyMin), rr.rdata);
        exp_lat <= LatencyMin;
        a = addr_t'(take_bits(24));
        mem_write(a, word_t'(take_bits(16)));
        mem_read("latency min read", a);
        reg_access(1'b1, RegLatency, 32'd9, rr);
        reg_access(1'b0, RegLatency, '0, rr);
        check("latency readback", 32'd9, rr.rdata);
        exp_lat <= 4'd9;
        mem_write(a, word_t'(take_bits(16)));
        mem_read("latency 9 read", a);
        end_test("latency");

        reg_access(1'b1, RegCount, 32'd5, rr);
        check("count write error", 32'd1, 32'(rr.error));
        reg_access(1'b0, 8'h08, '0, rr);
        check("unknown read error", 32'd1, 32'(rr.error));
        reg_access(1'b1, 8'h10, 32'd3, rr);
        check("unknown write error", 32'd1, 32'(rr.error));
        reg_access(1'b0, RegLatency, '0, rr);
        check("latency unchanged", 32'd9, rr.rdata);
        check("latency read error", 32'd0, 32'(rr.error));
        end_test("reg_error");

        // Three writes to one address, the PHY holds the first response
        @(posedge sys_clk);
        rsp_ready <= 1'b0;
        a = addr_t'(take_bits(24));
        for (int i = 0; i < 3; i++) begin
            d[i] = word_t'(take_bits(16));
        end
        send_req(1'b1, a, d[0]);
        @(negedge sys_clk);
        while (!rsp_valid) @(negedge sys_clk);
        held = rsp;
        send_req(1'b1, a, d[1]);
        send_req(1'b1, a, d[2]);
        stall = 2 + int'(take_bits(3));
        for (int i = 0; i < stall; i++) begin
            @(negedge sys_clk);
            check("queue full ready", 32'd0, 32'(req_ready));
            check("held valid", 32'd1, 32'(rsp_valid));
            check("held response", 32'(held), 32'(rsp));
        end
        @(posedge sys_clk);
        rsp_ready <= 1'b1;
        for (int i = 0; i < 3; i++) begin
            get_rsp(r);
            check("back_pressure flag", 32'd1, 32'(r.write));
        end
        ref_mem[a[7:0]] = d[2];
        mem_read("back_pressure read", a);
        end_test("back_pressure");

        reg_access(1'b0, RegCount, '0, rr);
        check("count", 32'(accepted), rr.rdata);
        end_test("count");

        $display("Tests %0d, failed %0d, errors %0d", tests, failed, errors + model_errors);
        if (errors + model_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* list.f */
design/hyper_cfg_pkg.sv
design/hyper_bus_pkg.sv
design/hyper_regs.sv
design/hyper_req_queue.sv
design/hyper_phy.sv
design/hyper_ctrl.sv
tests/hyper_mem_model.sv
tests/hyper_ctrl_tb.sv

/* Makefile */
TOP := hyper_ctrl_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)
	verilator --lint-only -f design/../list.f --top-module hyper_ctrl \
		design/hyper_cfg_pkg.sv design/hyper_bus_pkg.sv design/hyper_regs.sv \
		design/hyper_req_queue.sv design/hyper_phy.sv design/hyper_ctrl.sv \
		|| true

sim:
	verilator --binary --timing -f list.f --top-module $(TOP) -o sim_$(TOP)
	out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir
